//--- design/iq_defines.svh
`ifndef IQ_DEFINES_SVH
`define IQ_DEFINES_SVH

// --------------------
// Register file and queue sizing
`define NUM_PHYS_REGS 64
`define LOG_PHYS      ($clog2(`NUM_PHYS_REGS))  // Tag width, 6 bits for 64 registers
`define QUEUE_SIZE    16
`define LOG_QUEUE     ($clog2(`QUEUE_SIZE))     // Slot index width

// Datapath widths
`define DATA_W        32
`define OP_W          6                         // Opcode field of a micro-op

`endif

//--- design/uop_pkg.sv
`include "iq_defines.svh"

// Instruction-side types shared by the dispatch path and the issue queue
package uop_pkg;

    // --------------------
    // Field types
    typedef logic [`LOG_PHYS-1:0] phys_reg_t;  // Physical register tag
    typedef logic [`OP_W-1:0]     opcode_t;    // ALU operation selector
    typedef logic [4:0]           shamt_t;     // Immediate shift amount from 0 to 31

    // --------------------
    // Static fields of one queue entry
    // The source values and ready bits change while the entry waits, so the
    // queue keeps those in separate arrays next to this struct
    typedef struct packed {
        opcode_t   op;        // Operation for the ALU
        phys_reg_t src1;      // First source tag compared against wakeup dest
        phys_reg_t src2;      // Second source tag
        shamt_t    shift;     // Used by SLL and SRL only
        phys_reg_t dest;      // Destination tag broadcast on completion
        logic      regwrite;  // Result is written back and wakes consumers
    } uop_t;

endpackage

//--- design/exec_pkg.sv
`include "iq_defines.svh"

// Execution-side types: operand words, queue slot index and ALU opcodes
package exec_pkg;

    import uop_pkg::*;

    // --------------------
    // Datapath types
    typedef logic [`DATA_W-1:0]    data_t;      // Operand or result word
    typedef logic [`LOG_QUEUE-1:0] iq_index_t;  // Slot position inside the issue queue

    // --------------------
    // Opcode encodings understood by int_alu
    // Arithmetic
    localparam opcode_t OP_ADD = 6'h00;
    localparam opcode_t OP_SUB = 6'h01;

    // Bitwise logic
    localparam opcode_t OP_AND = 6'h02;
    localparam opcode_t OP_OR  = 6'h03;
    localparam opcode_t OP_XOR = 6'h04;

    // Shifts take their amount from the shift field, not from src2
    localparam opcode_t OP_SLL = 6'h05;
    localparam opcode_t OP_SRL = 6'h06;

    // Signed set-less-than, result is 0 or 1
    localparam opcode_t OP_SLT = 6'h07;

endpackage

//--- design/wakeup_if.sv
`timescale 1ns/1ps

// Result broadcast from the ALU
// Every waiting queue entry and the register file snoop it in the same cycle
interface wakeup_if
    import uop_pkg::*, exec_pkg::*;
();
    logic      valid;     // One cycle per completed micro-op
    phys_reg_t dest;      // Tag of the produced register
    data_t     value;     // Result word
    logic      regwrite;  // Low for micro-ops that write nothing

    // The ALU owns the bus
    modport producer (output valid, output dest, output value, output regwrite);

    // Queue and register file only listen
    modport consumer (input valid, input dest, input value, input regwrite);

endinterface

//--- design/issue_if.sv
`timescale 1ns/1ps

// Selected micro-op travelling from the issue queue to the ALU
// Both operands are already resolved, so the ALU never reads the register file
interface issue_if
    import uop_pkg::*, exec_pkg::*;
();
    logic      valid;     // Single-cycle pulse per issued micro-op
    opcode_t   op;
    data_t     src1_val;
    data_t     src2_val;
    shamt_t    shift;
    phys_reg_t dest;
    logic      regwrite;

    // Queue side, all fields registered
    modport source (output valid, output op, output src1_val, output src2_val,
                    output shift, output dest, output regwrite);

    // ALU side, always accepts
    modport sink   (input valid, input op, input src1_val, input src2_val,
                    input shift, input dest, input regwrite);

endinterface

//--- design/phys_reg_file.sv
`timescale 1ns/1ps
`include "iq_defines.svh"

module phys_reg_file
    import uop_pkg::*, exec_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      init_write,   // Preload port, used before dispatch starts
    input  phys_reg_t init_reg,
    input  data_t     init_value,
    input  logic      alloc_valid,  // Dispatch of a micro-op that writes alloc_dest
    input  phys_reg_t alloc_dest,
    input  phys_reg_t rd_src1,
    input  phys_reg_t rd_src2,
    output data_t     rd1_val,
    output logic      rd1_ready,
    output data_t     rd2_val,
    output logic      rd2_ready,
    wakeup_if.consumer wakeup
);

    data_t                     regs [`NUM_PHYS_REGS];
    logic [`NUM_PHYS_REGS-1:0] ready;        // One bit per tag, set means value is final

    logic bus_hit;                           // Broadcast that actually writes back
    logic hit1;
    logic hit2;

    assign bus_hit = wakeup.valid && wakeup.regwrite;
    assign hit1    = bus_hit && (wakeup.dest == rd_src1);
    assign hit2    = bus_hit && (wakeup.dest == rd_src2);

    // --------------------
    // Dispatch reads
    // A result broadcast in the same cycle is forwarded so the new entry
    // never misses its wakeup
    assign rd1_val   = hit1 ? wakeup.value : regs[rd_src1];
    assign rd1_ready = hit1 | ready[rd_src1];
    assign rd2_val   = hit2 ? wakeup.value : regs[rd_src2];
    assign rd2_ready = hit2 | ready[rd_src2];

    // --------------------
    // Writes and ready tracking
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
                regs[i] <= '0;                // Every register starts as a ready zero
            end
            ready <= '1;
        end else begin
            if (init_write) begin
                regs[init_reg]  <= init_value;
                ready[init_reg] <= 1'b1;
            end
            if (bus_hit) begin
                regs[wakeup.dest]  <= wakeup.value;
                ready[wakeup.dest] <= 1'b1;
            end
            // Allocation comes last, a fresh writer always makes the tag busy
            if (alloc_valid) ready[alloc_dest] <= 1'b0;
        end
    end

endmodule

//--- design/issue_queue.sv
`timescale 1ns/1ps
`include "iq_defines.svh"

module issue_queue
    import uop_pkg::*, exec_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      enq_valid,
    input  opcode_t   enq_op,
    input  shamt_t    enq_shift,
    input  phys_reg_t enq_dest,
    input  logic      enq_regwrite,
    input  phys_reg_t enq_src1,
    input  data_t     enq_src1_val,
    input  logic      enq_src1_ready,
    input  phys_reg_t enq_src2,
    input  data_t     enq_src2_val,
    input  logic      enq_src2_ready,
    output logic      enq_accept,
    output logic      full,
    input  logic      issue_stall,    // Holds every entry in place while high
    wakeup_if.consumer wakeup,
    issue_if.source   issue
);

    // --------------------
    // Entry storage, slot 0 is always the oldest
    uop_t  q_uop      [`QUEUE_SIZE];
    data_t q_src1_val [`QUEUE_SIZE];
    data_t q_src2_val [`QUEUE_SIZE];
    logic  q_src1_rdy [`QUEUE_SIZE];
    logic  q_src2_rdy [`QUEUE_SIZE];

    logic [`LOG_QUEUE:0] count;          // Occupied slots, 0 to QUEUE_SIZE
    logic [`LOG_QUEUE:0] count_next;
    iq_index_t           tail;           // First free slot while not full

    // Entry state after this cycle's wakeup
    logic [`QUEUE_SIZE-1:0] src1_hit;
    logic [`QUEUE_SIZE-1:0] src2_hit;
    data_t w_src1_val [`QUEUE_SIZE];
    data_t w_src2_val [`QUEUE_SIZE];
    logic  w_src1_rdy [`QUEUE_SIZE];
    logic  w_src2_rdy [`QUEUE_SIZE];
    logic [`QUEUE_SIZE-1:0] ready_vec;   // Valid and both sources available

    logic      bus_hit;
    logic      sel_found;
    iq_index_t sel_idx;
    logic      do_issue;
    iq_index_t wr_slot;
    uop_t      enq_uop;

    assign bus_hit = wakeup.valid && wakeup.regwrite;
    assign tail    = count[`LOG_QUEUE-1:0];

    // --------------------
    // Wakeup, tag match against the broadcast
    always_comb begin
        for (int i = 0; i < `QUEUE_SIZE; i++) begin
            src1_hit[i]   = bus_hit && (q_uop[i].src1 == wakeup.dest);
            src2_hit[i]   = bus_hit && (q_uop[i].src2 == wakeup.dest);
            w_src1_rdy[i] = q_src1_rdy[i] | src1_hit[i];
            w_src2_rdy[i] = q_src2_rdy[i] | src2_hit[i];
            w_src1_val[i] = src1_hit[i] ? wakeup.value : q_src1_val[i];
            w_src2_val[i] = src2_hit[i] ? wakeup.value : q_src2_val[i];
            ready_vec[i]  = (i < count) && w_src1_rdy[i] && w_src2_rdy[i];  // Empty slots never win
        end
    end

    // --------------------
    // Select the oldest ready entry
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        // Walk down so the lowest index is the last one written
        for (int i = `QUEUE_SIZE - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                sel_found = 1'b1;
                sel_idx   = iq_index_t'(i);
            end
        end
    end

    assign do_issue   = sel_found && !issue_stall;
    assign enq_accept = enq_valid && !full;            // Registered full, so no path from select
    assign wr_slot    = do_issue ? tail - 1'b1 : tail; // Tail moves down when a slot is removed

    assign enq_uop = '{op: enq_op, src1: enq_src1, src2: enq_src2, shift: enq_shift,
                       dest: enq_dest, regwrite: enq_regwrite};

    always_comb begin
        case ({enq_accept, do_issue})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;               // Both or neither keep the count
        endcase
    end

    // --------------------
    // Control state
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            count       <= '0;
            full        <= 1'b0;
            issue.valid <= 1'b0;
        end else begin
            count       <= count_next;
            full        <= (count_next == `QUEUE_SIZE);
            issue.valid <= do_issue;                   // One pulse per selected entry
        end
    end

    // Payload, compaction and enqueue
    always_ff @(posedge CLK) begin
        // Slots at and above the issued one take the younger neighbour
        for (int i = 0; i < `QUEUE_SIZE - 1; i++) begin
            if (do_issue && (iq_index_t'(i) >= sel_idx)) begin
                q_uop[i]      <= q_uop[i+1];
                q_src1_val[i] <= w_src1_val[i+1];
                q_src2_val[i] <= w_src2_val[i+1];
                q_src1_rdy[i] <= w_src1_rdy[i+1];
                q_src2_rdy[i] <= w_src2_rdy[i+1];
            end else begin
                q_src1_val[i] <= w_src1_val[i];
                q_src2_val[i] <= w_src2_val[i];
                q_src1_rdy[i] <= w_src1_rdy[i];
                q_src2_rdy[i] <= w_src2_rdy[i];
            end
        end
        // Top slot has no neighbour, it just keeps its woken state
        q_src1_val[`QUEUE_SIZE-1] <= w_src1_val[`QUEUE_SIZE-1];
        q_src2_val[`QUEUE_SIZE-1] <= w_src2_val[`QUEUE_SIZE-1];
        q_src1_rdy[`QUEUE_SIZE-1] <= w_src1_rdy[`QUEUE_SIZE-1];
        q_src2_rdy[`QUEUE_SIZE-1] <= w_src2_rdy[`QUEUE_SIZE-1];

        // New entry lands behind the compacted ones
        if (enq_accept) begin
            q_uop[wr_slot]      <= enq_uop;
            q_src1_val[wr_slot] <= enq_src1_val;
            q_src2_val[wr_slot] <= enq_src2_val;
            q_src1_rdy[wr_slot] <= enq_src1_ready;
            q_src2_rdy[wr_slot] <= enq_src2_ready;
        end

        if (do_issue) begin
            issue.op       <= q_uop[sel_idx].op;
            issue.src1_val <= w_src1_val[sel_idx];   // Includes a value woken this cycle
            issue.src2_val <= w_src2_val[sel_idx];
            issue.shift    <= q_uop[sel_idx].shift;
            issue.dest     <= q_uop[sel_idx].dest;
            issue.regwrite <= q_uop[sel_idx].regwrite;
        end
    end

endmodule

//--- design/int_alu.sv
`timescale 1ns/1ps

module int_alu
    import exec_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    issue_if.sink      issue,
    wakeup_if.producer wakeup
);

    data_t alu_result;

    // --------------------
    // Operation decode
    always_comb begin
        case (issue.op)
            OP_ADD:  alu_result = issue.src1_val + issue.src2_val;
            OP_SUB:  alu_result = issue.src1_val - issue.src2_val;
            OP_AND:  alu_result = issue.src1_val & issue.src2_val;
            OP_OR:   alu_result = issue.src1_val | issue.src2_val;
            OP_XOR:  alu_result = issue.src1_val ^ issue.src2_val;
            // Shift amount comes from the micro-op, src2 is ignored
            OP_SLL:  alu_result = issue.src1_val << issue.shift;
            OP_SRL:  alu_result = issue.src1_val >> issue.shift;  // Logical, zero fill
            OP_SLT:  begin
                // Two's complement compare
                alu_result = data_t'($signed(issue.src1_val) < $signed(issue.src2_val));
            end
            default: alu_result = '0;                             // Unknown opcodes give zero
        endcase
    end

    // --------------------
    // Result stage
    // A new micro-op may arrive every cycle while the previous one broadcasts
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            wakeup.valid <= 1'b0;
        end else begin
            wakeup.valid <= issue.valid;
        end
    end

    // Payload only moves when there is something to broadcast
    always_ff @(posedge CLK) begin
        if (issue.valid) begin
            wakeup.value    <= alu_result;
            wakeup.dest     <= issue.dest;
            wakeup.regwrite <= issue.regwrite;
        end
    end

endmodule

//--- design/ooo_exec_top.sv
`timescale 1ns/1ps

module ooo_exec_top
    import uop_pkg::*, exec_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    // Preload, sets a value and marks the register ready
    input  logic      init_write,
    input  phys_reg_t init_reg,
    input  data_t     init_value,
    // Dispatch
    input  logic      dispatch_valid,
    input  opcode_t   dispatch_op,
    input  phys_reg_t dispatch_src1,
    input  phys_reg_t dispatch_src2,
    input  shamt_t    dispatch_shift,
    input  phys_reg_t dispatch_dest,
    input  logic      dispatch_regwrite,
    output logic      dispatch_accept,  // Same-cycle pulse
    output logic      iq_full,
    input  logic      issue_stall,
    // Completed results as seen on the wakeup bus
    output logic      result_valid,
    output phys_reg_t result_dest,
    output data_t     result_value
);

    wakeup_if wk ();
    issue_if  iss ();

    data_t src1_val;
    data_t src2_val;
    logic  src1_ready;
    logic  src2_ready;
    logic  alloc_valid;

    // Only micro-ops that write back make their destination busy
    assign alloc_valid = dispatch_accept && dispatch_regwrite;

    // --------------------
    phys_reg_file i_phys_reg_file (
        .CLK         (CLK),
        .RESET       (RESET),
        .init_write  (init_write),
        .init_reg    (init_reg),
        .init_value  (init_value),
        .alloc_valid (alloc_valid),
        .alloc_dest  (dispatch_dest),
        .rd_src1     (dispatch_src1),
        .rd_src2     (dispatch_src2),
        .rd1_val     (src1_val),
        .rd1_ready   (src1_ready),
        .rd2_val     (src2_val),
        .rd2_ready   (src2_ready),
        .wakeup      (wk.consumer)
    );

    issue_queue i_issue_queue (
        .CLK            (CLK),
        .RESET          (RESET),
        .enq_valid      (dispatch_valid),
        .enq_op         (dispatch_op),
        .enq_shift      (dispatch_shift),
        .enq_dest       (dispatch_dest),
        .enq_regwrite   (dispatch_regwrite),
        .enq_src1       (dispatch_src1),
        .enq_src1_val   (src1_val),
        .enq_src1_ready (src1_ready),
        .enq_src2       (dispatch_src2),
        .enq_src2_val   (src2_val),
        .enq_src2_ready (src2_ready),
        .enq_accept     (dispatch_accept),
        .full           (iq_full),
        .issue_stall    (issue_stall),
        .wakeup         (wk.consumer),
        .issue          (iss.source)
    );

    int_alu i_int_alu (
        .CLK    (CLK),
        .RESET  (RESET),
        .issue  (iss.sink),
        .wakeup (wk.producer)
    );

    // --------------------
    // Result ports show only broadcasts that write back
    assign result_valid = wk.valid && wk.regwrite;
    assign result_dest  = wk.dest;
    assign result_value = wk.value;

endmodule

//--- tests/tb_ooo_exec.sv
`timescale 1ns/1ps
`include "iq_defines.svh"

module tb_ooo_exec
    import uop_pkg::*, exec_pkg::*;
();

    // --------------------
    // Stimulus table
    localparam int K_PRELOAD  = 0;
    localparam int K_DISPATCH = 1;   // Repeated until the queue accepts it
    localparam int K_STALL    = 2;   // Value 0 releases, 1 holds, 2 picks a random level per cycle
    localparam int K_REJECT   = 3;   // Dispatch that a full queue must refuse for hold cycles
    localparam int K_DRAIN    = 4;   // Waits for every outstanding result, hold is an estimate

    typedef struct {
        int        kind;
        opcode_t   op;
        phys_reg_t src1;
        phys_reg_t src2;
        shamt_t    shift;
        phys_reg_t dest;
        logic      regwrite;
        data_t     value;            // Preload value or stall mode
        int        hold;             // Idle cycles after the row
    } row_t;

    logic      CLK;
    logic      RESET;
    logic      init_write;
    phys_reg_t init_reg;
    data_t     init_value;
    logic      dispatch_valid;
    opcode_t   dispatch_op;
    phys_reg_t dispatch_src1;
    phys_reg_t dispatch_src2;
    shamt_t    dispatch_shift;
    phys_reg_t dispatch_dest;
    logic      dispatch_regwrite;
    logic      dispatch_accept;
    logic      iq_full;
    logic      issue_stall;
    logic      result_valid;
    phys_reg_t result_dest;
    data_t     result_value;

    row_t      rows [$];
    data_t     model_val [`NUM_PHYS_REGS];  // Architectural value after every accepted dispatch
    data_t     exp_val   [`NUM_PHYS_REGS];  // Result still owed for each busy tag
    phys_reg_t src1_of   [`NUM_PHYS_REGS];
    phys_reg_t src2_of   [`NUM_PHYS_REGS];
    logic [`NUM_PHYS_REGS-1:0] pending;     // Writer in flight
    logic [`NUM_PHYS_REGS-1:0] dep1;        // Source 1 had a writer in flight at dispatch
    logic [`NUM_PHYS_REGS-1:0] dep2;
    int        errors = 0;
    int        outstanding = 0;
    int        accepted_writes = 0;
    int        results_seen = 0;
    int        cycles = 0;
    int        cycle_limit = 1000000;       // Replaced once the table is built
    int        stall_mode = 0;
    logic      quiet = 1'b0;                // No result may appear while set

    ooo_exec_top i_ooo_exec_top (
        .CLK (CLK), .RESET (RESET),
        .init_write (init_write), .init_reg (init_reg), .init_value (init_value),
        .dispatch_valid (dispatch_valid), .dispatch_op (dispatch_op),
        .dispatch_src1 (dispatch_src1), .dispatch_src2 (dispatch_src2),
        .dispatch_shift (dispatch_shift), .dispatch_dest (dispatch_dest),
        .dispatch_regwrite (dispatch_regwrite), .dispatch_accept (dispatch_accept),
        .iq_full (iq_full), .issue_stall (issue_stall),
        .result_valid (result_valid), .result_dest (result_dest), .result_value (result_value)
    );

    always #5 CLK = ~CLK;

    // --------------------
    // Helpers
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // Expected ALU result from the opcode definitions
    function automatic data_t alu_model(input opcode_t op, input data_t a, input data_t b,
                                        input shamt_t sh);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a + ~b + 32'd1;            // Two's complement subtract
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            // Different signs decide by the sign of a, equal signs by plain magnitude
            OP_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            default: return '0;
        endcase
    endfunction

    task automatic append_row(input int kind, input opcode_t op, input int src1, input int src2,
                              input int shift, input int dest, input int regwrite,
                              input data_t value, input int hold);
        row_t r;
        r.kind = kind;
        r.op = op;
        r.src1 = phys_reg_t'(src1);
        r.src2 = phys_reg_t'(src2);
        r.shift = shamt_t'(shift);
        r.dest = phys_reg_t'(dest);
        r.regwrite = (regwrite != 0);
        r.value = value;
        r.hold = hold;
        rows.push_back(r);
    endtask

    // Next drive point, 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge CLK);
        #1;
        if (stall_mode == 2) issue_stall = ($urandom % 3) == 0;
    endtask

    task automatic drive_fields(input row_t r);
        dispatch_op       = r.op;
        dispatch_src1     = r.src1;
        dispatch_src2     = r.src2;
        dispatch_shift    = r.shift;
        dispatch_dest     = r.dest;
        dispatch_regwrite = r.regwrite;
    endtask

    task automatic record_dispatch(input row_t r);
        data_t expected;
        expected = alu_model(r.op, model_val[r.src1], model_val[r.src2], r.shift);
        if (r.regwrite) begin                         // Only writers owe a result
            model_val[r.dest] = expected;
            exp_val[r.dest]   = expected;
            src1_of[r.dest]   = r.src1;
            src2_of[r.dest]   = r.src2;
            dep1[r.dest]      = pending[r.src1];
            dep2[r.dest]      = pending[r.src2];
            pending[r.dest]   = 1'b1;
            outstanding++;
            accepted_writes++;
        end
    endtask

    task automatic apply_row(input row_t r);
        logic accepted;
        accepted = 1'b0;
        case (r.kind)
            K_PRELOAD: begin
                init_write = 1'b1;
                init_reg   = r.dest;
                init_value = r.value;
                model_val[r.dest] = r.value;
                step_cycle();
                init_write = 1'b0;
            end
            K_DISPATCH: begin
                drive_fields(r);
                dispatch_valid = 1'b1;
                while (!accepted) begin
                    @(negedge CLK);                    // Accept is combinational, stable here
                    if (dispatch_accept) begin
                        accepted = 1'b1;
                        record_dispatch(r);
                    end
                    step_cycle();
                end
                dispatch_valid = 1'b0;
            end
            K_STALL: begin
                stall_mode  = int'(r.value);
                issue_stall = (stall_mode == 1);
                quiet       = (stall_mode == 1);       // Queue is drained before a hold
                step_cycle();
            end
            K_REJECT: begin
                drive_fields(r);
                dispatch_valid = 1'b1;
                repeat (r.hold) begin
                    @(negedge CLK);
                    check_value(32'(dispatch_accept), 32'd0, "dispatch_accept with a full queue");
                    check_value(32'(iq_full), 32'd1, "iq_full after sixteen stalled dispatches");
                    step_cycle();
                end
                dispatch_valid = 1'b0;
            end
            default: begin
                while (outstanding != 0) step_cycle();
            end
        endcase
        if (r.kind == K_PRELOAD || r.kind == K_DISPATCH || r.kind == K_STALL) begin
            repeat (r.hold) step_cycle();
        end
    endtask

    task automatic build_table();
        // Preloads, register 5 is negative for the signed compare
        append_row(K_PRELOAD, OP_ADD, 0, 0, 0, 1, 0, 32'h0000_0015, 0);
        append_row(K_PRELOAD, OP_ADD, 0, 0, 0, 2, 0, 32'h0000_0007, 0);
        append_row(K_PRELOAD, OP_ADD, 0, 0, 0, 3, 0, 32'hF0F0_1234, 0);
        append_row(K_PRELOAD, OP_ADD, 0, 0, 0, 4, 0, 32'h0F0F_00FF, 0);
        append_row(K_PRELOAD, OP_ADD, 0, 0, 0, 5, 0, 32'hFFFF_FFF0, 0);
        append_row(K_PRELOAD, OP_ADD, 0, 0, 0, 6, 0, 32'h1234_5678, 0);
        append_row(K_PRELOAD, OP_ADD, 0, 0, 0, 7, 0, 32'h8000_0001, 0);
        append_row(K_PRELOAD, OP_ADD, 0, 0, 0, 8, 0, 32'h0000_0003, 0);
        append_row(K_DISPATCH, OP_ADD, 1, 0, 0, 9, 1, '0, 2);    // Reads back a preload
        // Every opcode on independent operands
        append_row(K_DISPATCH, OP_ADD, 1, 2, 0, 10, 1, '0, 0);
        append_row(K_DISPATCH, OP_SUB, 2, 1, 0, 11, 1, '0, 0);
        append_row(K_DISPATCH, OP_AND, 3, 4, 0, 12, 1, '0, 0);
        append_row(K_DISPATCH, OP_OR,  3, 4, 0, 13, 1, '0, 0);
        append_row(K_DISPATCH, OP_XOR, 6, 7, 0, 14, 1, '0, 0);
        append_row(K_DISPATCH, OP_SLL, 6, 0, 4, 15, 1, '0, 0);
        append_row(K_DISPATCH, OP_SRL, 7, 0, 31, 16, 1, '0, 0);
        append_row(K_DISPATCH, OP_SLT, 5, 6, 0, 17, 1, '0, 0);
        // Dependent chain, each reads the previous destination
        append_row(K_DISPATCH, OP_ADD, 1, 2, 0, 20, 1, '0, 0);
        append_row(K_DISPATCH, OP_SUB, 20, 3, 0, 21, 1, '0, 0);
        append_row(K_DISPATCH, OP_XOR, 21, 4, 0, 22, 1, '0, 0);
        append_row(K_DISPATCH, OP_SLL, 22, 0, 3, 23, 1, '0, 0);
        append_row(K_DISPATCH, OP_SLT, 23, 5, 0, 24, 1, '0, 0);
        append_row(K_DISPATCH, OP_ADD, 24, 24, 0, 25, 1, '0, 0);
        append_row(K_DRAIN, OP_ADD, 0, 0, 0, 0, 0, '0, 40);
        // Fill the queue behind a held stall
        append_row(K_STALL, OP_ADD, 0, 0, 0, 0, 0, 32'd1, 1);
        for (int i = 0; i < `QUEUE_SIZE; i++) begin
            append_row(K_DISPATCH, opcode_t'(i % 8), (i % 2 == 1) ? 29 + i : 1 + i % 8,
                       2 + i % 7, i, 30 + i, 1, '0, 0);
        end
        append_row(K_REJECT, OP_ADD, 1, 2, 0, 46, 1, '0, 3);
        append_row(K_STALL, OP_ADD, 0, 0, 0, 0, 0, 32'd0, 0);
        append_row(K_DRAIN, OP_ADD, 0, 0, 0, 0, 0, '0, 60);
        // Random stall with mixed dependencies, one non-writing micro-op
        append_row(K_STALL, OP_ADD, 0, 0, 0, 0, 0, 32'd2, 0);
        for (int i = 0; i < 16; i++) begin
            append_row(K_DISPATCH, opcode_t'((i * 5) % 8), (i % 3 != 0) ? 47 + i : 1 + i % 8,
                       (i % 4 == 0 && i > 0) ? 46 + i : 1 + (i * 3) % 8, i * 2 + 1, 48 + i,
                       (i == 9) ? 0 : 1, '0, (i % 3 == 2) ? 2 : 0);
        end
        append_row(K_DRAIN, OP_ADD, 0, 0, 0, 0, 0, '0, 80);
        append_row(K_STALL, OP_ADD, 0, 0, 0, 0, 0, 32'd0, 2);
    endtask

    // --------------------
    // Result monitor, outputs are registered so the falling edge sees them settled
    always @(negedge CLK) begin
        if (RESET && result_valid) begin
            if (quiet) begin
                $display("Error at %0t ns: result for tag %0d while issue was stalled",
                         $time, result_dest);
                errors++;
            end
            if (!pending[result_dest]) begin
                $display("Error at %0t ns: unexpected result for tag %0d", $time, result_dest);
                errors++;
            end else begin
                check_value(result_value, exp_val[result_dest],
                            $sformatf("result value for tag %0d", result_dest));
                if ((dep1[result_dest] && pending[src1_of[result_dest]]) ||
                    (dep2[result_dest] && pending[src2_of[result_dest]])) begin
                    $display("Error at %0t ns: tag %0d finished before its producer",
                             $time, result_dest);
                    errors++;
                end
                pending[result_dest] = 1'b0;
                outstanding--;
                results_seen++;
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // --------------------
    // Main sequence
    initial begin
        int table_cycles;
        table_cycles = 0;
        void'($urandom(60));
        CLK = 1'b0;
        RESET = 1'b0;
        init_write = 1'b0;
        init_reg = '0;
        init_value = '0;
        dispatch_valid = 1'b0;
        dispatch_op = OP_ADD;
        dispatch_src1 = '0;
        dispatch_src2 = '0;
        dispatch_shift = '0;
        dispatch_dest = '0;
        dispatch_regwrite = 1'b0;
        issue_stall = 1'b0;
        pending = '0;
        dep1 = '0;
        dep2 = '0;
        foreach (model_val[i]) model_val[i] = '0;     // Matches the reset state of the register file
        build_table();
        foreach (rows[i]) table_cycles += rows[i].hold + 1;
        cycle_limit = 20 * (table_cycles + 8);
        repeat (8) @(posedge CLK);
        #1 RESET = 1'b1;
        @(negedge CLK);
        check_value(32'(result_valid), 32'd0, "result_valid after reset");
        check_value(32'(iq_full), 32'd0, "iq_full after reset");
        step_cycle();
        foreach (rows[i]) apply_row(rows[i]);
        check_value(results_seen, accepted_writes, "results against accepted writing dispatches");
        $display("Errors: %0d, results checked: %0d, writing dispatches: %0d",
                 errors, results_seen, accepted_writes);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+design
design/uop_pkg.sv
design/exec_pkg.sv
design/wakeup_if.sv
design/issue_if.sv
design/phys_reg_file.sv
design/issue_queue.sv
design/int_alu.sv
design/ooo_exec_top.sv
tests/tb_ooo_exec.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f project.f --top-module tb_ooo_exec -o sim_ooo_exec

# The exit status follows the search for the pass line
out=$(./obj_dir/sim_ooo_exec)
echo "$out"
echo "$out" | grep -qx "Done: no errors"
